// ==== sim.f ====
+incdir+.
soc_pkg.sv
wb_interconnect.sv
ram_target.sv
sys_manager.sv
main_partition.sv
tb_main_partition.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_main_partition \
  -f sim.f \
  -o sim_main_partition

if ! ./obj_dir/sim_main_partition > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
  exit 1
fi

// ==== tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: we, adr, sel, wdata, expected read data, expected proc_rst_n_o
// Read data is only compared on reads

task automatic load_vectors();
  // Reset state and ID register
  add_vector(1'b0, 32'h3000_1000, 4'hF, 32'h0000_0000, 32'h0000_0000, 1'b0); // CTRL cleared
  add_vector(1'b0, 32'h3000_1008, 4'hF, 32'h0000_0000, 32'h4D50_0001, 1'b0); // ID value
  add_vector(1'b1, 32'h3000_1008, 4'hF, 32'hDEAD_BEEF, 32'h0000_0000, 1'b0); // Write to ID
  add_vector(1'b0, 32'h3000_1008, 4'hF, 32'h0000_0000, 32'h4D50_0001, 1'b0); // ID unchanged

  // RAM byte lanes, one word updated lane by lane
  add_vector(1'b1, 32'h3000_0010, 4'hF, 32'h1122_3344, 32'h0000_0000, 1'b0);
  add_vector(1'b0, 32'h3000_0010, 4'hF, 32'h0000_0000, 32'h1122_3344, 1'b0);
  add_vector(1'b1, 32'h3000_0010, 4'h1, 32'hAAAA_AA55, 32'h0000_0000, 1'b0); // Lane 0 only
  add_vector(1'b0, 32'h3000_0010, 4'hF, 32'h0000_0000, 32'h1122_3355, 1'b0);
  add_vector(1'b1, 32'h3000_0010, 4'h4, 32'h0066_0000, 32'h0000_0000, 1'b0); // Lane 2 only
  add_vector(1'b0, 32'h3000_0010, 4'hF, 32'h0000_0000, 32'h1166_3355, 1'b0);
  add_vector(1'b1, 32'h3000_0010, 4'hC, 32'h7788_0000, 32'h0000_0000, 1'b0); // Upper half
  add_vector(1'b0, 32'h3000_0010, 4'hF, 32'h0000_0000, 32'h7788_3355, 1'b0);
  add_vector(1'b1, 32'h3000_0010, 4'h3, 32'hABCD_9999, 32'h0000_0000, 1'b0); // Lower half
  add_vector(1'b0, 32'h3000_0010, 4'hF, 32'h0000_0000, 32'h7788_9999, 1'b0);

  // Upper 2 kB alias the lower half
  add_vector(1'b1, 32'h3000_0804, 4'hF, 32'hCAFE_F00D, 32'h0000_0000, 1'b0);
  add_vector(1'b0, 32'h3000_0004, 4'hF, 32'h0000_0000, 32'hCAFE_F00D, 1'b0);
  add_vector(1'b0, 32'h3000_0804, 4'hF, 32'h0000_0000, 32'hCAFE_F00D, 1'b0);

  // Processor reset control and scratch
  add_vector(1'b1, 32'h3000_1000, 4'hF, 32'h0000_0001, 32'h0000_0000, 1'b1); // Release
  add_vector(1'b0, 32'h3000_1000, 4'hF, 32'h0000_0000, 32'h0000_0001, 1'b1);
  add_vector(1'b1, 32'h3000_1004, 4'hF, 32'h1234_5678, 32'h0000_0000, 1'b1);
  add_vector(1'b0, 32'h3000_1004, 4'hF, 32'h0000_0000, 32'h1234_5678, 1'b1);
  add_vector(1'b1, 32'h3000_1004, 4'h0, 32'hFFFF_FFFF, 32'h0000_0000, 1'b1); // No lanes
  add_vector(1'b0, 32'h3000_1004, 4'hF, 32'h0000_0000, 32'h1234_5678, 1'b1);
  add_vector(1'b1, 32'h3000_1000, 4'hF, 32'h0000_0000, 32'h0000_0000, 1'b0); // Hold again
  add_vector(1'b0, 32'h3000_1000, 4'hF, 32'h0000_0000, 32'h0000_0000, 1'b0);

  // Unmapped accesses, then read-back of both targets
  add_vector(1'b1, 32'h3000_0000, 4'hF, 32'h5A5A_0000, 32'h0000_0000, 1'b0);
  add_vector(1'b0, 32'h3000_2000, 4'hF, 32'h0000_0000, 32'h0000_0000, 1'b0); // Past SYS
  add_vector(1'b1, 32'h2000_0000, 4'hF, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0); // Below RAM
  add_vector(1'b0, 32'h3000_1000, 4'hF, 32'h0000_0000, 32'h0000_0000, 1'b0);
  add_vector(1'b0, 32'h3000_1004, 4'hF, 32'h0000_0000, 32'h1234_5678, 1'b0);
  add_vector(1'b0, 32'h3000_0000, 4'hF, 32'h0000_0000, 32'h5A5A_0000, 1'b0);
endtask

`endif

// ==== tb_main_partition.sv ====
`timescale 1ns/1ps

module tb_main_partition;

  ////////////////////
  // Constants
  ////////////////////

  localparam int RANDOM_WRITES = 64;
  localparam int RANDOM_TXNS   = 2 * RANDOM_WRITES; // Writes plus read-backs
  localparam int ACK_WAIT_MAX  = 8;  // Cycles before a transfer is given up
  localparam int IDX_W = $clog2(soc_pkg::RAM_WORDS_DEFAULT);

  ////////////////////
  // DUT signals
  ////////////////////

  logic              wb_clk;
  logic              rst_n;
  logic              wbs_cyc;
  logic              wbs_stb;
  logic              wbs_we;
  soc_pkg::wb_sel_t  wbs_sel;
  soc_pkg::wb_addr_t wbs_adr;
  soc_pkg::wb_data_t wbs_dat_w; // Master write data
  logic              wbs_ack;
  soc_pkg::wb_data_t wbs_dat_r; // Read data from the DUT
  logic              proc_rst_n;

  // Stimulus table
  logic              vec_we    [$];
  soc_pkg::wb_addr_t vec_adr   [$];
  soc_pkg::wb_sel_t  vec_sel   [$];
  soc_pkg::wb_data_t vec_wdata [$];
  soc_pkg::wb_data_t vec_rdata [$];
  logic              vec_prst  [$];

  soc_pkg::wb_data_t shadow [soc_pkg::RAM_WORDS_DEFAULT]; // Expected RAM words
  logic [IDX_W-1:0]  rnd_idx [$];

  int error_count   = 0;
  int check_count   = 0;
  int cycle_count   = 0;
  int timeout_limit = 0;

  main_partition u_main_partition (
    .wb_clk_i     (wb_clk    ),
    .rst_n_i      (rst_n     ),
    .wbs_cyc_i    (wbs_cyc   ),
    .wbs_stb_i    (wbs_stb   ),
    .wbs_we_i     (wbs_we    ),
    .wbs_sel_i    (wbs_sel   ),
    .wbs_adr_i    (wbs_adr   ),
    .wbs_dat_i    (wbs_dat_w ),
    .wbs_ack_o    (wbs_ack   ),
    .wbs_dat_o    (wbs_dat_r ),
    .proc_rst_n_o (proc_rst_n)
  );

  initial begin
    wb_clk = 1'b0;
    forever #50 wb_clk = ~wb_clk; // 100 ns period
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic add_vector(input logic we, input soc_pkg::wb_addr_t adr,
                            input soc_pkg::wb_sel_t sel, input soc_pkg::wb_data_t wdata,
                            input soc_pkg::wb_data_t rdata, input logic prst);
    vec_we.push_back(we);
    vec_adr.push_back(adr);
    vec_sel.push_back(sel);
    vec_wdata.push_back(wdata);
    vec_rdata.push_back(rdata);
    vec_prst.push_back(prst);
  endtask

  `include "tb_vectors.svh"

  task automatic compare_values(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
    check_count++;
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s, got %08h, expected %08h",
               $time, what, actual, expected);
      error_count++;
    end
  endtask

  task automatic print_summary();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
  endtask

  // One classic cycle, ack latency and width checked on the way
  task automatic run_transfer(input logic we, input soc_pkg::wb_addr_t adr,
                              input soc_pkg::wb_sel_t sel, input soc_pkg::wb_data_t wdata,
                              input soc_pkg::wb_data_t exp_rdata, input logic exp_prst,
                              input string tag);
    int                wait_cycles;
    logic              got_ack;
    soc_pkg::wb_data_t rdata;
    wait_cycles = 0;
    got_ack     = 1'b0;
    rdata       = '0;
    @(posedge wb_clk);
    wbs_cyc   <= 1'b1;
    wbs_stb   <= 1'b1;
    wbs_we    <= we;
    wbs_sel   <= sel;
    wbs_adr   <= adr;
    wbs_dat_w <= wdata;
    while (!got_ack && wait_cycles < ACK_WAIT_MAX) begin
      @(negedge wb_clk); // Outputs settled mid-cycle
      wait_cycles++;
      if (wbs_ack) begin
        got_ack = 1'b1;
        rdata   = wbs_dat_r;
      end
    end
    if (!got_ack) begin
      $display("No acknowledge for %s within %0d cycles", tag, ACK_WAIT_MAX);
      error_count++;
    end else begin
      compare_values(32'(wait_cycles), 32'd2, {tag, " ack latency"});
      if (!we) begin
        compare_values(rdata, exp_rdata, {tag, " read data"});
      end
    end
    @(posedge wb_clk); // Strobe still sampled high at this edge
    wbs_cyc <= 1'b0;
    wbs_stb <= 1'b0;
    wbs_we  <= 1'b0;
    @(negedge wb_clk);
    if (got_ack) begin
      compare_values({31'h0, wbs_ack}, 32'h0, {tag, " ack longer than one cycle"});
    end
    compare_values({31'h0, proc_rst_n}, {31'h0, exp_prst}, {tag, " proc_rst_n_o"});
  endtask

  ////////////////////
  // Timeout
  ////////////////////

  always @(posedge wb_clk) begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      error_count++;
      print_summary();
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    logic [31:0]       rnd;
    logic [IDX_W-1:0]  idx;
    soc_pkg::wb_addr_t addr;
    // Idle bus, reset asserted
    rst_n     = 1'b0;
    wbs_cyc   = 1'b0;
    wbs_stb   = 1'b0;
    wbs_we    = 1'b0;
    wbs_sel   = '0;
    wbs_adr   = '0;
    wbs_dat_w = '0;
    void'($urandom(32'h9970));
    load_vectors();
    timeout_limit = 10 * vec_we.size() + 10 * RANDOM_TXNS + 100;

    repeat (5) @(posedge wb_clk);
    rst_n <= 1'b1;
    @(negedge wb_clk);
    compare_values({31'h0, proc_rst_n}, 32'h0, "proc_rst_n_o after reset");
    compare_values({31'h0, wbs_ack}, 32'h0, "ack after reset");
    compare_values(wbs_dat_r, 32'h0, "read data after reset");

    // Directed table
    for (int i = 0; i < vec_we.size(); i++) begin
      run_transfer(vec_we[i], vec_adr[i], vec_sel[i], vec_wdata[i], vec_rdata[i],
                   vec_prst[i], $sformatf("vector %0d", i));
    end

    // Random RAM words, full lanes
    for (int i = 0; i < RANDOM_WRITES; i++) begin
      rnd = $urandom;
      idx = rnd[IDX_W-1:0];
      rnd = $urandom;
      shadow[idx] = rnd; // Last write to an index wins
      rnd_idx.push_back(idx);
      addr = soc_pkg::RAM_BASE | {{(30-IDX_W){1'b0}}, idx, 2'b00};
      run_transfer(1'b1, addr, 4'hF, rnd, 32'h0, 1'b0, $sformatf("random write %0d", i));
    end
    for (int i = 0; i < RANDOM_WRITES; i++) begin
      idx  = rnd_idx[i];
      addr = soc_pkg::RAM_BASE | {{(30-IDX_W){1'b0}}, idx, 2'b00};
      run_transfer(1'b0, addr, 4'hF, 32'h0, shadow[idx], 1'b0,
                   $sformatf("random read %0d", i));
    end

    print_summary();
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== main_partition.sv ====
`timescale 1ns/1ps

module main_partition #(
  parameter int unsigned RAM_WORDS = soc_pkg::RAM_WORDS_DEFAULT // RAM depth in words
) (
  input  logic              wb_clk_i    , // Bus clock
  input  logic              rst_n_i     , // Synchronous reset, active low

  // Wishbone slave port
  input  logic              wbs_cyc_i   ,
  input  logic              wbs_stb_i   ,
  input  logic              wbs_we_i    ,
  input  soc_pkg::wb_sel_t  wbs_sel_i   ,
  input  soc_pkg::wb_addr_t wbs_adr_i   ,
  input  soc_pkg::wb_data_t wbs_dat_i   ,
  output logic              wbs_ack_o   ,
  output soc_pkg::wb_data_t wbs_dat_o   ,

  output logic              proc_rst_n_o  // Processor reset, active low
);

  ////////////////////
  // Target wires
  ////////////////////

  logic              ram_stb;
  logic              ram_ack;
  soc_pkg::wb_data_t ram_dat;

  logic              sys_stb;
  logic              sys_ack;
  soc_pkg::wb_data_t sys_dat;

  ////////////////////
  // Address decode and response combine
  ////////////////////

  wb_interconnect u_wb_interconnect (
    .wb_clk_i  (wb_clk_i ),
    .rst_n_i   (rst_n_i  ),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_stb_i (wbs_stb_i),
    .wbs_adr_i (wbs_adr_i),
    .ram_stb_o (ram_stb  ),
    .sys_stb_o (sys_stb  ),
    .ram_ack_i (ram_ack  ),
    .sys_ack_i (sys_ack  ),
    .ram_dat_i (ram_dat  ),
    .sys_dat_i (sys_dat  ),
    .wbs_ack_o (wbs_ack_o),
    .wbs_dat_o (wbs_dat_o)
  );

  ////////////////////
  // Targets
  ////////////////////

  // 0x3000_0000 window
  ram_target #(
    .RAM_WORDS (RAM_WORDS)
  ) u_ram_target (
    .wb_clk_i  (wb_clk_i ),
    .rst_n_i   (rst_n_i  ),
    .stb_i     (ram_stb  ),
    .we_i      (wbs_we_i ), // Shared request lines
    .sel_i     (wbs_sel_i),
    .adr_i     (wbs_adr_i),
    .dat_i     (wbs_dat_i),
    .ack_o     (ram_ack  ),
    .dat_o     (ram_dat  )
  );

  // 0x3000_1000 window
  sys_manager u_sys_manager (
    .wb_clk_i     (wb_clk_i    ),
    .rst_n_i      (rst_n_i     ),
    .stb_i        (sys_stb     ),
    .we_i         (wbs_we_i    ),
    .sel_i        (wbs_sel_i   ),
    .adr_i        (wbs_adr_i   ),
    .dat_i        (wbs_dat_i   ),
    .ack_o        (sys_ack     ),
    .dat_o        (sys_dat     ),
    .proc_rst_n_o (proc_rst_n_o)
  );

endmodule

// ==== sys_manager.sv ====
`timescale 1ns/1ps

module sys_manager (
  input  logic              wb_clk_i    , // Bus clock
  input  logic              rst_n_i     , // Synchronous reset, active low

  // Wishbone slave
  input  logic              stb_i       , // Strobe already qualified by cyc and window
  input  logic              we_i        ,
  input  soc_pkg::wb_sel_t  sel_i       ,
  input  soc_pkg::wb_addr_t adr_i       ,
  input  soc_pkg::wb_data_t dat_i       ,
  output logic              ack_o       ,
  output soc_pkg::wb_data_t dat_o       ,

  // Processor control
  output logic              proc_rst_n_o  // Low holds the processor in reset
);

  ////////////////////
  // Signals
  ////////////////////

  soc_pkg::sys_ofs_t reg_ofs; // Register select
  logic              access;  // New request this cycle
  logic              wr_en;   // Write with at least one lane set
  logic              ack_q;

  logic              ctrl_q;    // CTRL bit 0
  soc_pkg::wb_data_t scratch_q; // SCRATCH word
  soc_pkg::wb_data_t rd_mux;    // Selected read value
  soc_pkg::wb_data_t rd_q;      // Registered read word

  // Bits 3:2 only, registers repeat every 16 bytes
  assign reg_ofs = adr_i[3:2];

  assign access = stb_i & ~ack_q;
  assign wr_en  = access & we_i & (|sel_i);

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      ctrl_q    <= 1'b0; // Processor held in reset
      scratch_q <= '0;
    end else if (wr_en) begin
      if (reg_ofs == soc_pkg::SYS_CTRL_OFS) begin
        ctrl_q <= dat_i[0];
      end
      if (reg_ofs == soc_pkg::SYS_SCRATCH_OFS) begin
        scratch_q <= dat_i; // Whole word, sel only needs to be nonzero
      end
      // ID and offset 3 ignore writes
    end
  end

  assign proc_rst_n_o = ctrl_q;

  ////////////////////
  // Read path
  ////////////////////

  always_comb begin
    case (reg_ofs)
      soc_pkg::SYS_CTRL_OFS:    rd_mux = {{($bits(rd_mux)-1){1'b0}}, ctrl_q};
      soc_pkg::SYS_SCRATCH_OFS: rd_mux = scratch_q;
      soc_pkg::SYS_ID_OFS:      rd_mux = soc_pkg::SYS_ID_VALUE;
      default:                  rd_mux = '0; // Offset 3 reads zero
    endcase
  end

  // Read word captured with the ack, zero for writes
  always_ff @(posedge wb_clk_i) begin
    if (access) begin
      rd_q <= we_i ? '0 : rd_mux;
    end
  end

  ////////////////////
  // Handshake
  ////////////////////

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  assign ack_o = ack_q;
  assign dat_o = ack_q ? rd_q : '0; // Zero when idle

  // Every ack answers a strobe seen one cycle earlier
  assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    ack_o |-> $past(stb_i))
    else $error("System manager ack without a preceding strobe");

endmodule

// ==== ram_target.sv ====
`timescale 1ns/1ps

module ram_target #(
  parameter int unsigned RAM_WORDS = soc_pkg::RAM_WORDS_DEFAULT // Depth, power of two
) (
  input  logic              wb_clk_i, // Bus clock
  input  logic              rst_n_i , // Synchronous reset, active low

  // Wishbone slave
  input  logic              stb_i   , // Strobe already qualified by cyc and window
  input  logic              we_i    ,
  input  soc_pkg::wb_sel_t  sel_i   ,
  input  soc_pkg::wb_addr_t adr_i   ,
  input  soc_pkg::wb_data_t dat_i   ,
  output logic              ack_o   ,
  output soc_pkg::wb_data_t dat_o
);

  ////////////////////
  // Local parameters
  ////////////////////

  localparam int unsigned IDX_W = $clog2(RAM_WORDS); // Word index width
  localparam int unsigned LANES = $bits(soc_pkg::wb_sel_t);

  typedef logic [IDX_W-1:0] ram_idx_t;

  ////////////////////
  // Signals
  ////////////////////

  soc_pkg::wb_data_t mem [RAM_WORDS]; // Word storage, not reset

  ram_idx_t          ram_idx; // Word index from the byte address
  logic              access;  // New request this cycle
  logic              wr_en;
  logic              ack_q;
  soc_pkg::wb_data_t rd_q;    // Registered read word

  // Bits above the index are ignored, upper window half aliases
  assign ram_idx = adr_i[IDX_W+1:2];

  // No second answer while ack is still high
  assign access = stb_i & ~ack_q;
  assign wr_en  = access & we_i;

  ////////////////////
  // Storage
  ////////////////////

  // Byte-lane write
  always_ff @(posedge wb_clk_i) begin
    if (wr_en) begin
      for (int lane = 0; lane < LANES; lane++) begin
        if (sel_i[lane]) begin
          mem[ram_idx][8*lane +: 8] <= dat_i[8*lane +: 8];
        end
      end
    end
  end

  // Read word captured with the ack, zero for writes
  always_ff @(posedge wb_clk_i) begin
    if (access) begin
      rd_q <= we_i ? '0 : mem[ram_idx];
    end
  end

  ////////////////////
  // Handshake
  ////////////////////

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access; // Single-cycle pulse
    end
  end

  assign ack_o = ack_q;
  assign dat_o = ack_q ? rd_q : '0; // Quiet when idle for the OR combine

  // Held strobe must not produce back-to-back acks
  assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    ack_o |=> !ack_o)
    else $error("RAM ack high for two cycles in a row");

endmodule

// ==== wb_interconnect.sv ====
`timescale 1ns/1ps

module wb_interconnect (
  input  logic             wb_clk_i , // Bus clock
  input  logic             rst_n_i  , // Synchronous reset, active low

  // Master request
  input  logic             wbs_cyc_i,
  input  logic             wbs_stb_i,
  input  soc_pkg::wb_addr_t wbs_adr_i,

  // Target strobes
  output logic             ram_stb_o,
  output logic             sys_stb_o,

  // Target responses
  input  logic             ram_ack_i,
  input  logic             sys_ack_i,
  input  soc_pkg::wb_data_t ram_dat_i,
  input  soc_pkg::wb_data_t sys_dat_i,

  // Master response
  output logic             wbs_ack_o,
  output soc_pkg::wb_data_t wbs_dat_o
);

  ////////////////////
  // Window decode
  ////////////////////

  localparam int unsigned WB = soc_pkg::WINDOW_BITS; // Lowest decoded bit

  logic req;      // Valid cycle from the master
  logic ram_hit;  // Address inside the RAM window
  logic sys_hit;  // Address inside the system manager window
  logic miss_stb; // Address matches no window
  logic miss_ack_q;

  assign req = wbs_cyc_i & wbs_stb_i;

  // Compare upper address bits with each base
  assign ram_hit = (wbs_adr_i[31:WB] == soc_pkg::RAM_BASE[31:WB]);
  assign sys_hit = (wbs_adr_i[31:WB] == soc_pkg::SYS_BASE[31:WB]);

  // Windows are disjoint, so at most one strobe rises
  assign ram_stb_o = req & ram_hit;
  assign sys_stb_o = req & sys_hit;
  assign miss_stb  = req & ~ram_hit & ~sys_hit;

  ////////////////////
  // Unmapped responder
  ////////////////////

  // One-cycle ack so the bus never hangs
  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      miss_ack_q <= 1'b0;
    end else begin
      miss_ack_q <= miss_stb & ~miss_ack_q; // Ack must fall before the next one
    end
  end

  ////////////////////
  // Response combine
  ////////////////////

  // Idle targets drive zero data, so a plain OR is enough
  assign wbs_ack_o = ram_ack_i | sys_ack_i | miss_ack_q;
  assign wbs_dat_o = ram_dat_i | sys_dat_i; // Unmapped reads return zero

  // Only one responder may answer in a cycle
  assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    $onehot0({ram_ack_i, sys_ack_i, miss_ack_q}))
    else $error("More than one Wishbone target acknowledged");

endmodule

// ==== soc_pkg.sv ====
package soc_pkg;

  ////////////////////
  // Bus widths
  ////////////////////

  localparam int unsigned ADDR_W = 32; // Wishbone byte address
  localparam int unsigned DATA_W = 32; // One data word
  localparam int unsigned SEL_W  = DATA_W / 8; // One select per byte lane

  typedef logic [ADDR_W-1:0] wb_addr_t; // Byte address on the bus
  typedef logic [DATA_W-1:0] wb_data_t; // Read or write data word
  typedef logic [SEL_W-1:0]  wb_sel_t;  // Byte-lane selects

  ////////////////////
  // Address map
  ////////////////////

  // Each window is 4 kB, decoded on bits 31 down to WINDOW_BITS
  localparam int unsigned WINDOW_BITS = 12;

  localparam wb_addr_t RAM_BASE = 32'h3000_0000; // Word RAM
  localparam wb_addr_t SYS_BASE = 32'h3000_1000; // System manager

  // Default RAM depth, 2 kB of words
  localparam int unsigned RAM_WORDS_DEFAULT = 512;

  ////////////////////
  // System manager registers
  ////////////////////

  // Register select, taken from address bits 3:2
  typedef logic [1:0] sys_ofs_t;

  localparam sys_ofs_t SYS_CTRL_OFS    = 2'd0; // Bit 0 drives the processor reset
  localparam sys_ofs_t SYS_SCRATCH_OFS = 2'd1; // Free 32-bit word
  localparam sys_ofs_t SYS_ID_OFS      = 2'd2; // Read-only identification

  // Value returned by the ID register
  localparam wb_data_t SYS_ID_VALUE = 32'h4D50_0001;

endpackage
